/* sublane_consts.svh */
`ifndef SUBLANE_CONSTS_SVH
`define SUBLANE_CONSTS_SVH

// lanes served by one driver
`define SUBLANE_LANES 8

// vrf words per lane
`define SUBLANE_MEM_DEPTH 512

// max elements one lane holds for a single vector
`define SUBLANE_MAX_EL 256

`endif

/* vrf_types_pkg.sv */
`include "sublane_consts.svh"

package vrf_types_pkg;

   typedef logic [$clog2(`SUBLANE_MEM_DEPTH)-1:0] vaddr_t;               // word address
   typedef logic [$clog2(`SUBLANE_LANES*`SUBLANE_MAX_EL)-1:0] vlen_t;    // whole vector
   typedef logic [$clog2(`SUBLANE_MAX_EL):0] elcnt_t;                    // 0 .. max inclusive
   typedef logic [1:0] sew_t;
   typedef logic [3:0] bwen_t;                   // one bit per byte of a 32-bit word

   // element width codes
   localparam sew_t SEW_BYTE = 2'd0;
   localparam sew_t SEW_HALF = 2'd1;
   localparam sew_t SEW_WORD = 2'd2;

endpackage

/* sublane_ctrl_pkg.sv */
package sublane_ctrl_pkg;

   typedef enum logic [1:0] {
      INST_NORMAL = 2'd0,   // read, write back after the delay
      INST_STORE  = 2'd1,   // read only, data goes to the store unit
      INST_LOAD   = 2'd2    // write beats from the load unit
   } inst_type_e;           // code 3 has no meaning

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_NORMAL,
      ST_STORE,
      ST_LOAD
   } drv_state_e;

endpackage

/* sublane_ctrl_if.sv */
`timescale 1ns/1ps

interface sublane_ctrl_if
   import vrf_types_pkg::*;
();

   // driven by the fsm
   logic start_pulse;   // acceptance cycle
   logic has_write;     // instruction has a write phase
   logic rd_step;
   logic wr_step;
   sew_t rd_sew;
   sew_t wr_sew;
   logic load_mode;

   // driven by the timer
   logic rd_phase;
   logic wr_phase;
   logic done;          // last cycle of the instruction

   modport fsm (
      output start_pulse, has_write, rd_step, wr_step, rd_sew, wr_sew, load_mode,
      input  rd_phase, wr_phase, done
   );

   modport timer (
      input  start_pulse,
      output rd_phase, wr_phase, done
   );

   // data side, byte enable generation
   modport bwen (
      input start_pulse, wr_step, wr_sew, load_mode
   );

endinterface

/* sublane_fsm.sv */
`timescale 1ns/1ps

module sublane_fsm
   import vrf_types_pkg::*;
   import sublane_ctrl_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        start_i,
   input  inst_type_e  inst_type_i,
   input  sew_t        sew_i,
   input  logic        load_valid_i,
   input  logic        load_last_i,
   sublane_ctrl_if.fsm ctrl,
   output logic        ready_o,
   output logic        store_data_valid_o,
   output logic        ready_for_load_o
);

   drv_state_e state_q;
   drv_state_e state_d;
   inst_type_e type_q;
   sew_t       sew_q;
   sew_t       sew_eff;
   logic       start_pulse;
   logic       load_end;

   assign start_pulse = start_i && ready_o;
   assign load_end    = load_valid_i && load_last_i;   // final beat from the load unit

   ////////////////////////////////////////////////////////////////////////////
   // state and captured instruction
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         state_q <= ST_IDLE;
         type_q  <= INST_NORMAL;
         sew_q   <= SEW_BYTE;
      end else begin
         state_q <= state_d;
         if (start_pulse) begin
            type_q <= inst_type_i;
            sew_q  <= sew_i;
         end
      end
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (start_pulse) begin
               case (inst_type_i)
                  INST_NORMAL: state_d = ST_NORMAL;
                  INST_STORE:  state_d = ST_STORE;
                  INST_LOAD:   state_d = ST_LOAD;
                  default:     state_d = ST_IDLE;   // unused code, just hand back ready
               endcase
            end
         end
         ST_NORMAL, ST_STORE: begin
            if (ctrl.done) begin
               state_d = ST_IDLE;
            end
         end
         ST_LOAD: begin
            if (load_end) begin
               state_d = ST_IDLE;
            end
         end
         default: state_d = ST_IDLE;
      endcase
   end

   // falls on acceptance, rises on the edge that returns to idle
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         ready_o <= 1'b1;
      end else if (start_pulse) begin
         ready_o <= 1'b0;
      end else if (!ready_o && state_d == ST_IDLE) begin
         ready_o <= 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // step and mode outputs
   ////////////////////////////////////////////////////////////////////////////

   assign sew_eff = (type_q == INST_NORMAL) ? sew_q : SEW_WORD;   // store/load use words

   assign ctrl.start_pulse = start_pulse;
   assign ctrl.has_write   = (inst_type_i == INST_NORMAL);
   assign ctrl.rd_step     = (state_q == ST_NORMAL || state_q == ST_STORE) && ctrl.rd_phase;
   assign ctrl.wr_step     = (state_q == ST_NORMAL && ctrl.wr_phase) ||
                             (state_q == ST_LOAD && load_valid_i);   // stall holds everything
   assign ctrl.rd_sew      = sew_eff;
   assign ctrl.wr_sew      = sew_eff;
   assign ctrl.load_mode   = (state_q == ST_LOAD);

   assign store_data_valid_o = (state_q == ST_STORE) && ctrl.rd_phase;
   assign ready_for_load_o   = (state_q == ST_LOAD);

endmodule

/* phase_timer.sv */
`timescale 1ns/1ps
`include "sublane_consts.svh"

module phase_timer
   import vrf_types_pkg::*;
(
   input  logic          clk_i,
   input  logic          rst_i,
   input  vlen_t         vl_i,
   input  elcnt_t        inst_delay_i,
   input  logic          has_write_i,
   sublane_ctrl_if.timer ctrl
);

   localparam int LANE_BITS = $clog2(`SUBLANE_LANES);

   typedef logic [$bits(elcnt_t):0] cyc_t;   // one bit more, holds delay plus length

   cyc_t   cnt_q;
   cyc_t   wr_end;
   cyc_t   last;
   elcnt_t len_in;
   elcnt_t len_q;
   elcnt_t delay_q;
   logic   has_write_q;
   logic   running_q;

   // elements per lane, rounded up
   assign len_in = elcnt_t'(vl_i >> LANE_BITS) + elcnt_t'(vl_i[LANE_BITS-1:0] != '0);

   always_ff @(posedge clk_i) begin
      if (ctrl.start_pulse) begin
         len_q       <= len_in;
         delay_q     <= inst_delay_i;
         has_write_q <= has_write_i;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // cycle counter
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         running_q <= 1'b0;
         cnt_q     <= '0;
      end else if (ctrl.start_pulse) begin
         running_q <= 1'b1;
         cnt_q     <= '0;
      end else if (running_q) begin
         cnt_q <= cnt_q + cyc_t'(1);
         if (ctrl.done) begin
            running_q <= 1'b0;
         end
      end
   end

   assign wr_end = cyc_t'(delay_q) + cyc_t'(len_q);
   assign last   = has_write_q ? wr_end : cyc_t'(len_q);   // no write phase, end after reads

   assign ctrl.rd_phase = running_q && (cnt_q < cyc_t'(len_q));
   assign ctrl.wr_phase = running_q && has_write_q &&
                          (cnt_q >= cyc_t'(delay_q)) && (cnt_q < wr_end);
   assign ctrl.done     = running_q && (cnt_q + cyc_t'(1) >= last);

endmodule

/* vrf_addr_gen.sv */
`timescale 1ns/1ps

module vrf_addr_gen
   import vrf_types_pkg::*;
(
   input  logic   clk_i,
   input  logic   rst_i,
   input  logic   load_i,
   input  vaddr_t start_addr_i,
   input  logic   step_i,
   input  sew_t   sew_i,
   output vaddr_t addr_o
);

   logic [1:0] pos_q;          // element slot inside the current word
   logic       last_in_word;

   always_comb begin
      case (sew_i)
         SEW_BYTE: last_in_word = (pos_q == 2'd3);
         SEW_HALF: last_in_word = (pos_q == 2'd1);
         default:  last_in_word = 1'b1;   // word, every element is a new word
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         addr_o <= '0;
         pos_q  <= '0;
      end else if (load_i) begin
         addr_o <= start_addr_i;
         pos_q  <= '0;
      end else if (step_i) begin
         if (last_in_word) begin
            addr_o <= addr_o + vaddr_t'(1);
            pos_q  <= '0;
         end else begin
            pos_q <= pos_q + 2'd1;
         end
      end
   end

endmodule

/* byte_enable_gen.sv */
`timescale 1ns/1ps
`include "sublane_consts.svh"

module byte_enable_gen
   import vrf_types_pkg::*;
(
   input  logic                        clk_i,
   input  logic                        rst_i,
   sublane_ctrl_if.bwen                ctrl,
   input  bwen_t [`SUBLANE_LANES-1:0]  load_bwen_i,
   output bwen_t [`SUBLANE_LANES-1:0]  bwen_o
);

   bwen_t      rot4_q;   // byte position, one-hot
   logic [1:0] rot2_q;   // halfword position, one-hot
   bwen_t      pattern;

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         rot4_q <= 4'b0001;
         rot2_q <= 2'b01;
      end else if (ctrl.start_pulse) begin
         rot4_q <= 4'b0001;   // element 0 sits in the low byte
         rot2_q <= 2'b01;
      end else if (ctrl.wr_step) begin
         rot4_q <= {rot4_q[2:0], rot4_q[3]};
         rot2_q <= {rot2_q[0], rot2_q[1]};
      end
   end

   always_comb begin
      case (ctrl.wr_sew)
         SEW_BYTE: pattern = rot4_q;
         SEW_HALF: pattern = {{2{rot2_q[1]}}, {2{rot2_q[0]}}};
         SEW_WORD: pattern = 4'b1111;
         default:  pattern = 4'b0000;
      endcase
   end

   // same pattern in every lane, load beats carry their own
   always_comb begin
      for (int i = 0; i < `SUBLANE_LANES; i++) begin
         if (ctrl.load_mode) begin
            bwen_o[i] = load_bwen_i[i] & {4{ctrl.wr_step}};
         end else begin
            bwen_o[i] = pattern & {4{ctrl.wr_step}};
         end
      end
   end

endmodule

/* sublane_driver.sv */
`timescale 1ns/1ps
`include "sublane_consts.svh"

module sublane_driver
   import vrf_types_pkg::*;
   import sublane_ctrl_pkg::*;
(
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        start_i,
   input  inst_type_e                  inst_type_i,
   input  vlen_t                       vl_i,
   input  sew_t                        sew_i,
   input  elcnt_t                      inst_delay_i,
   input  vaddr_t                      raddr_start_i,
   input  vaddr_t                      waddr_start_i,
   input  logic                        load_valid_i,
   input  logic                        load_last_i,
   input  bwen_t [`SUBLANE_LANES-1:0]  load_bwen_i,
   output logic                        ready_o,
   output logic                        vrf_ren_o,
   output vaddr_t                      vrf_raddr_o,
   output vaddr_t                      vrf_waddr_o,
   output bwen_t [`SUBLANE_LANES-1:0]  vrf_bwen_o,
   output logic                        store_data_valid_o,
   output logic                        ready_for_load_o
);

   sublane_ctrl_if ctrl_if ();

   sublane_fsm i_fsm (
      .clk_i              (clk_i),
      .rst_i              (rst_i),
      .start_i            (start_i),
      .inst_type_i        (inst_type_i),
      .sew_i              (sew_i),
      .load_valid_i       (load_valid_i),
      .load_last_i        (load_last_i),
      .ctrl               (ctrl_if.fsm),
      .ready_o            (ready_o),
      .store_data_valid_o (store_data_valid_o),
      .ready_for_load_o   (ready_for_load_o)
   );

   phase_timer i_phase_timer (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .vl_i         (vl_i),
      .inst_delay_i (inst_delay_i),
      .has_write_i  (ctrl_if.has_write),
      .ctrl         (ctrl_if.timer)
   );

   // read side
   vrf_addr_gen i_raddr_gen (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .load_i       (ctrl_if.start_pulse),
      .start_addr_i (raddr_start_i),
      .step_i       (ctrl_if.rd_step),
      .sew_i        (ctrl_if.rd_sew),
      .addr_o       (vrf_raddr_o)
   );

   // write side
   vrf_addr_gen i_waddr_gen (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .load_i       (ctrl_if.start_pulse),
      .start_addr_i (waddr_start_i),
      .step_i       (ctrl_if.wr_step),
      .sew_i        (ctrl_if.wr_sew),
      .addr_o       (vrf_waddr_o)
   );

   byte_enable_gen i_bwen_gen (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .ctrl        (ctrl_if.bwen),
      .load_bwen_i (load_bwen_i),
      .bwen_o      (vrf_bwen_o)
   );

   assign vrf_ren_o = ctrl_if.rd_step;   // one read per element step

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int CLK_PERIOD   = 8,
   parameter int RESET_CYCLES = 5
) (
   output logic clk_o,
   output logic rst_o   // active low
);

   initial begin
      clk_o = 1'b0;
      forever #(CLK_PERIOD / 2) clk_o = ~clk_o;
   end

   initial begin
      rst_o <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      rst_o <= 1'b1;
   end

endmodule

/* sublane_driver_tb.sv */
`timescale 1ns/1ps
`include "sublane_consts.svh"

module sublane_driver_tb
   import vrf_types_pkg::*;
   import sublane_ctrl_pkg::*;
();

   localparam int CLK_PERIOD   = 8;
   localparam int RESET_CYCLES = 5;
   // cycles from acceptance to ready per test, load allows two stalls per beat
   localparam int TEST_CYCLES  = (2 + 5 + 1) + (7 + 5 + 1) + (0 + 8 + 1) + (3 + 1) +
                                 (6 * 3 + 1) + 2;
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES + 6 * 4 + 40;

   logic                              clk;
   logic                              rst;
   logic                              start;
   inst_type_e                        inst_type;
   vlen_t                             vl;
   sew_t                              sew;
   elcnt_t                            inst_delay;
   vaddr_t                            raddr_start;
   vaddr_t                            waddr_start;
   logic                              load_valid;
   logic                              load_last;
   bwen_t [`SUBLANE_LANES-1:0]        load_bwen;
   logic                              ready;
   logic                              vrf_ren;
   vaddr_t                            vrf_raddr;
   vaddr_t                            vrf_waddr;
   bwen_t [`SUBLANE_LANES-1:0]        vrf_bwen;
   logic                              store_data_valid;
   logic                              ready_for_load;

   int test_errs  = 0;
   int total_errs = 0;
   int tests_run  = 0;
   int fail_tests = 0;

   tb_clock_gen #(.CLK_PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) i_clock_gen (
      .clk_o (clk),
      .rst_o (rst)
   );

   sublane_driver i_sublane_driver (
      .clk_i              (clk),
      .rst_i              (rst),
      .start_i            (start),
      .inst_type_i        (inst_type),
      .vl_i               (vl),
      .sew_i              (sew),
      .inst_delay_i       (inst_delay),
      .raddr_start_i      (raddr_start),
      .waddr_start_i      (waddr_start),
      .load_valid_i       (load_valid),
      .load_last_i        (load_last),
      .load_bwen_i        (load_bwen),
      .ready_o            (ready),
      .vrf_ren_o          (vrf_ren),
      .vrf_raddr_o        (vrf_raddr),
      .vrf_waddr_o        (vrf_waddr),
      .vrf_bwen_o         (vrf_bwen),
      .store_data_valid_o (store_data_valid),
      .ready_for_load_o   (ready_for_load)
   );

   ////////////////////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////////////////////

   function automatic int elem_count(input vlen_t vlen);
      return (int'(vlen) + `SUBLANE_LANES - 1) / `SUBLANE_LANES;   // rounded up
   endfunction

   function automatic vaddr_t elem_addr(input vaddr_t base, input sew_t esew, input int k);
      return vaddr_t'(int'(base) + (k >> (2 - int'(esew))));
   endfunction

   function automatic bwen_t bwen_pattern(input sew_t esew, input int k);
      case (esew)
         SEW_BYTE: return bwen_t'(1 << (k % 4));
         SEW_HALF: return (k % 2 == 0) ? 4'b0011 : 4'b1100;
         default:  return 4'b1111;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // bookkeeping and stimulus
   ////////////////////////////////////////////////////////////////////////////

   task automatic report_mismatch(input string sig, input logic [31:0] got,
                                  input logic [31:0] want);
      $display("MISMATCH time %0t: %s got 0x%0h, expected 0x%0h", $time, sig, got, want);
      test_errs++;
   endtask

   task automatic end_test(input string name);
      tests_run++;
      total_errs += test_errs;
      if (test_errs == 0) begin
         $display("test %s: ok", name);
      end else begin
         fail_tests++;
         $display("test %s: failed with %0d mismatches", name, test_errs);
      end
      test_errs = 0;
   endtask

   task automatic issue_instruction(input inst_type_e itype, input vlen_t vlen,
                                    input sew_t esew, input elcnt_t delay,
                                    input vaddr_t ra, input vaddr_t wa);
      @(negedge clk);
      while (ready !== 1'b1) @(negedge clk);
      @(posedge clk);
      start       <= 1'b1;
      inst_type   <= itype;
      vl          <= vlen;
      sew         <= esew;
      inst_delay  <= delay;
      raddr_start <= ra;
      waddr_start <= wa;
      @(posedge clk);   // acceptance edge
      start <= 1'b0;
   endtask

   task automatic check_idle_after_reset();
      @(negedge clk);
      if (ready !== 1'b1) report_mismatch("ready_o", 32'(ready), 32'd1);
      if (vrf_ren !== 1'b0) report_mismatch("vrf_ren_o", 32'(vrf_ren), 32'd0);
      if (store_data_valid !== 1'b0)
         report_mismatch("store_data_valid_o", 32'(store_data_valid), 32'd0);
      if (ready_for_load !== 1'b0)
         report_mismatch("ready_for_load_o", 32'(ready_for_load), 32'd0);
      if (vrf_bwen !== '0) report_mismatch("vrf_bwen_o", 32'(vrf_bwen), 32'd0);
   endtask

   // normal, store and the unused code, checked cycle by cycle until ready
   task automatic run_vector_op(input string name, input inst_type_e itype, input vlen_t vlen,
                                input sew_t esew, input elcnt_t delay, input vaddr_t ra,
                                input vaddr_t wa, input bit poke_start);
      int    len;
      int    dly;
      int    last_cyc;
      int    k;
      sew_t  use_sew;
      logic  exp_rdy;
      logic  exp_ren;
      logic  exp_sdv;
      logic  exp_wr;
      bwen_t exp_b;
      len      = elem_count(vlen);
      dly      = int'(delay);
      use_sew  = (itype == INST_NORMAL) ? esew : SEW_WORD;   // store works on words
      last_cyc = (itype == INST_NORMAL) ? dly + len : (itype == INST_STORE) ? len : 1;
      issue_instruction(itype, vlen, esew, delay, ra, wa);
      for (int c = 1; c <= last_cyc + 1; c++) begin
         @(negedge clk);
         k       = c - 1;
         exp_rdy = (c == last_cyc + 1);
         exp_ren = (itype == INST_NORMAL || itype == INST_STORE) && k < len;
         exp_sdv = exp_ren && itype == INST_STORE;
         exp_wr  = (itype == INST_NORMAL) && k >= dly && k < dly + len;
         if (ready !== exp_rdy) report_mismatch("ready_o", 32'(ready), 32'(exp_rdy));
         if (vrf_ren !== exp_ren) report_mismatch("vrf_ren_o", 32'(vrf_ren), 32'(exp_ren));
         if (exp_ren && vrf_raddr !== elem_addr(ra, use_sew, k))
            report_mismatch("vrf_raddr_o", 32'(vrf_raddr), 32'(elem_addr(ra, use_sew, k)));
         if (store_data_valid !== exp_sdv)
            report_mismatch("store_data_valid_o", 32'(store_data_valid), 32'(exp_sdv));
         if (ready_for_load !== 1'b0)
            report_mismatch("ready_for_load_o", 32'(ready_for_load), 32'd0);
         for (int i = 0; i < `SUBLANE_LANES; i++) begin
            exp_b = exp_wr ? bwen_pattern(use_sew, k - dly) : 4'b0000;
            if (vrf_bwen[i] !== exp_b)
               report_mismatch($sformatf("vrf_bwen_o[%0d]", i), 32'(vrf_bwen[i]), 32'(exp_b));
         end
         if (exp_wr && vrf_waddr !== elem_addr(wa, use_sew, k - dly))
            report_mismatch("vrf_waddr_o", 32'(vrf_waddr), 32'(elem_addr(wa, use_sew, k - dly)));
         if (poke_start && c == 2) begin
            @(posedge clk);
            start <= 1'b1;   // busy, must not restart
         end else if (poke_start && c == 3) begin
            @(posedge clk);
            start <= 1'b0;
         end
      end
      end_test(name);
   endtask

   // six beats, each after zero to two stall cycles
   task automatic load_test();
      int    stalls;
      logic  valid;
      bwen_t [`SUBLANE_LANES-1:0] beat_bwen;
      issue_instruction(INST_LOAD, 11'd48, SEW_BYTE, 9'd0, 9'h000, 9'h040);
      for (int beat = 0; beat < 6; beat++) begin
         stalls = int'($urandom % 3);
         for (int n = 0; n <= stalls; n++) begin
            valid      = (n == stalls);
            beat_bwen  = $urandom;   // stall cycles carry junk enables
            load_valid <= valid;
            load_last  <= valid && beat == 5;
            load_bwen  <= beat_bwen;
            @(negedge clk);
            if (ready !== 1'b0) report_mismatch("ready_o", 32'(ready), 32'd0);
            if (ready_for_load !== 1'b1)
               report_mismatch("ready_for_load_o", 32'(ready_for_load), 32'd1);
            if (vrf_ren !== 1'b0) report_mismatch("vrf_ren_o", 32'(vrf_ren), 32'd0);
            for (int i = 0; i < `SUBLANE_LANES; i++) begin
               if (vrf_bwen[i] !== (valid ? beat_bwen[i] : 4'b0000))
                  report_mismatch($sformatf("vrf_bwen_o[%0d]", i), 32'(vrf_bwen[i]),
                                  32'(valid ? beat_bwen[i] : 4'b0000));
            end
            if (vrf_waddr !== elem_addr(9'h040, SEW_WORD, beat))
               report_mismatch("vrf_waddr_o", 32'(vrf_waddr),
                               32'(elem_addr(9'h040, SEW_WORD, beat)));
            @(posedge clk);
         end
      end
      load_valid <= 1'b0;
      load_last  <= 1'b0;
      @(negedge clk);
      if (ready !== 1'b1) report_mismatch("ready_o", 32'(ready), 32'd1);
      if (ready_for_load !== 1'b0)
         report_mismatch("ready_for_load_o", 32'(ready_for_load), 32'd0);
      if (vrf_bwen !== '0) report_mismatch("vrf_bwen_o", 32'(vrf_bwen), 32'd0);
      end_test("5 load with stalls");
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      void'($urandom(1));
      start       <= 1'b0;
      inst_type   <= INST_NORMAL;
      vl          <= '0;
      sew         <= SEW_BYTE;
      inst_delay  <= '0;
      raddr_start <= '0;
      waddr_start <= '0;
      load_valid  <= 1'b0;
      load_last   <= 1'b0;
      load_bwen   <= '0;
      @(posedge rst);
      check_idle_after_reset();
      run_vector_op("1 normal byte", INST_NORMAL, 11'd40, SEW_BYTE, 9'd2, 9'h010, 9'h020, 1'b0);
      run_vector_op("2 normal half", INST_NORMAL, 11'd33, SEW_HALF, 9'd7, 9'h030, 9'h050, 1'b1);
      run_vector_op("3 normal word", INST_NORMAL, 11'd64, SEW_WORD, 9'd0, 9'h0f8, 9'h1fc, 1'b0);
      run_vector_op("4 store", INST_STORE, 11'd17, SEW_BYTE, 9'd4, 9'h100, 9'h000, 1'b0);
      load_test();
      run_vector_op("6 unused type", inst_type_e'(2'd3), 11'd16, SEW_WORD, 9'd1, 9'h000,
                    9'h000, 1'b0);
      $display("tests run %0d, failed %0d, mismatches %0d", tests_run, fail_tests, total_errs);
      if (fail_tests == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired, the DUT did not return ready_o in time");
      $display("=== FAIL ===");
      $finish;
   end

endmodule

/* project.f */
+incdir+.
vrf_types_pkg.sv
sublane_ctrl_pkg.sv
sublane_ctrl_if.sv
sublane_fsm.sv
phase_timer.sv
vrf_addr_gen.sv
byte_enable_gen.sv
sublane_driver.sv
tb_clock_gen.sv
sublane_driver_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the sublane driver testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module sublane_driver_tb -f project.f -o sublane_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/sublane_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -Fqx "=== PASS ==="; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1
